//--- rtl/helios_pkg.sv
package helios_pkg;

    // data and instruction width
    localparam int XLEN = 32;

    // architectural register number width
    localparam int REG_SEL = 5;

    // accepted major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

//--- rtl/insn_decoder.sv
`timescale 1ns/10ps

module insn_decoder
    import helios_pkg::*;
(
    input  logic [XLEN-1:0]    insn_i,
    output alu_op_e            alu_op_o,
    output logic [REG_SEL-1:0] rs1_o,
    output logic [REG_SEL-1:0] rs2_o,
    output logic [REG_SEL-1:0] rd_o,
    output logic               uses_rs2_o,
    output logic [XLEN-1:0]    imm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];

    assign rd_o  = insn_i[11:7];
    assign rs1_o = insn_i[19:15];
    assign rs2_o = insn_i[24:20];

    assign uses_rs2_o = (opcode == OPC_OP);

    // shift amount sits in the low five bits
    assign imm_o = {{(XLEN-12){insn_i[31]}}, insn_i[31:20]};

    always_comb begin
        case (funct3)
            // sub exists only in the register form
            3'b000:  alu_op_o = (uses_rs2_o && insn_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b011:  alu_op_o = ALU_SLTU;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = insn_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
        endcase
    end

endmodule

//--- rtl/rename_unit.sv
`timescale 1ns/10ps

module rename_unit
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              dispatch_i,
    input  alu_op_e                           alu_op_i,
    input  logic [REG_SEL-1:0]                rs1_i,
    input  logic [REG_SEL-1:0]                rs2_i,
    input  logic [REG_SEL-1:0]                rd_i,
    input  logic                              uses_rs2_i,
    input  logic [XLEN-1:0]                   imm_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]      tail_tag_i,
    input  logic                              bc_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]      bc_tag_i,
    input  logic [XLEN-1:0]                   bc_data_i,
    input  logic [ROB_DEPTH-1:0]              rob_done_i,
    input  logic [ROB_DEPTH-1:0][XLEN-1:0]    rob_data_i,
    input  logic                              commit_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]      commit_tag_i,
    input  logic [REG_SEL-1:0]                commit_rd_i,
    input  logic [XLEN-1:0]                   commit_data_i,
    output logic                              rs_write_o,
    output alu_op_e                           rs_op_o,
    output logic [$clog2(ROB_DEPTH)-1:0]      rs_tag_o,
    output logic [XLEN-1:0]                   rs_val1_o,
    output logic [XLEN-1:0]                   rs_val2_o,
    output logic                              rs_rdy1_o,
    output logic                              rs_rdy2_o,
    output logic [$clog2(ROB_DEPTH)-1:0]      rs_wait1_o,
    output logic [$clog2(ROB_DEPTH)-1:0]      rs_wait2_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int NREG  = 2 ** REG_SEL;

    logic [NREG-1:0][XLEN-1:0]  arf_q;
    logic [NREG-1:0]            busy_q;
    logic [NREG-1:0][TAG_W-1:0] map_q;

    logic [1:0][REG_SEL-1:0] src_reg;
    logic [1:0][XLEN-1:0]    src_val;
    logic [1:0]              src_rdy;
    logic [1:0][TAG_W-1:0]   src_wait;

    assign src_reg = {rs2_i, rs1_i};

    // operand source: arf, finished rob entry, live broadcast, else wait on tag
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_wait[s] = map_q[src_reg[s]];
            src_val[s]  = arf_q[src_reg[s]];
            src_rdy[s]  = 1'b1;
            if (src_reg[s] == '0) begin
                src_val[s] = '0;
            end else if (busy_q[src_reg[s]]) begin
                if (rob_done_i[src_wait[s]]) begin
                    src_val[s] = rob_data_i[src_wait[s]];
                end else if (bc_valid_i && bc_tag_i == src_wait[s]) begin
                    src_val[s] = bc_data_i;
                end else begin
                    src_rdy[s] = 1'b0;
                end
            end
        end
    end

    assign rs_write_o = dispatch_i;
    assign rs_op_o    = alu_op_i;
    assign rs_tag_o   = tail_tag_i;
    assign rs_val1_o  = src_val[0];
    assign rs_rdy1_o  = src_rdy[0];
    assign rs_wait1_o = src_wait[0];
    // op-imm takes the immediate as second operand
    assign rs_val2_o  = uses_rs2_i ? src_val[1] : imm_i;
    assign rs_rdy2_o  = !uses_rs2_i || src_rdy[1];
    assign rs_wait2_o = src_wait[1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            arf_q  <= '0;
            busy_q <= '0;
        end else begin
            if (commit_valid_i && commit_rd_i != '0) begin
                arf_q[commit_rd_i] <= commit_data_i;
                // only the latest producer releases the register
                if (map_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            if (dispatch_i && rd_i != '0) begin
                busy_q[rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            map_q[rd_i] <= tail_tag_i;
        end
    end

endmodule

//--- rtl/alu_rs.sv
`timescale 1ns/10ps

module alu_rs
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         rs_write_i,
    input  alu_op_e                      rs_op_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] rs_tag_i,
    input  logic [XLEN-1:0]              rs_val1_i,
    input  logic [XLEN-1:0]              rs_val2_i,
    input  logic                         rs_rdy1_i,
    input  logic                         rs_rdy2_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] rs_wait1_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] rs_wait2_i,
    input  logic                         bc_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] bc_tag_i,
    input  logic [XLEN-1:0]              bc_data_i,
    output logic                         issue_o,
    output alu_op_e                      issue_op_o,
    output logic [$clog2(ROB_DEPTH)-1:0] issue_tag_o,
    output logic [XLEN-1:0]              issue_a_o,
    output logic [XLEN-1:0]              issue_b_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // entries stay compacted, index 0 is the oldest
    logic [ROB_DEPTH-1:0] vld_q;
    logic [ROB_DEPTH-1:0] rdy1_q;
    logic [ROB_DEPTH-1:0] rdy2_q;
    alu_op_e              op_q    [ROB_DEPTH];
    logic [TAG_W-1:0]     tag_q   [ROB_DEPTH];
    logic [TAG_W-1:0]     wait1_q [ROB_DEPTH];
    logic [TAG_W-1:0]     wait2_q [ROB_DEPTH];
    logic [XLEN-1:0]      val1_q  [ROB_DEPTH];
    logic [XLEN-1:0]      val2_q  [ROB_DEPTH];

    logic [TAG_W-1:0]     sel;
    logic [TAG_W:0]       fill;
    logic [ROB_DEPTH-1:0] wake1;
    logic [ROB_DEPTH-1:0] wake2;
    logic [TAG_W-1:0]     src_idx [ROB_DEPTH];

    // lowest ready index is the oldest ready entry
    always_comb begin
        sel     = '0;
        issue_o = 1'b0;
        for (int i = ROB_DEPTH - 1; i >= 0; i--) begin
            if (vld_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                sel     = TAG_W'(i);
                issue_o = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            wake1[i]   = bc_valid_i && !rdy1_q[i] && wait1_q[i] == bc_tag_i;
            wake2[i]   = bc_valid_i && !rdy2_q[i] && wait2_q[i] == bc_tag_i;
            // entries above the issued one move down a slot
            src_idx[i] = (issue_o && i >= sel) ? TAG_W'(i + 1) : TAG_W'(i);
        end
    end

    assign fill        = (TAG_W + 1)'($countones(vld_q)) - (TAG_W + 1)'(issue_o);
    assign issue_op_o  = op_q[sel];
    assign issue_tag_o = tag_q[sel];
    assign issue_a_o   = val1_q[sel];
    assign issue_b_o   = val2_q[sel];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                vld_q[i] <= (i < fill + rs_write_i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (rs_write_i && fill == i) begin
                op_q[i]    <= rs_op_i;
                tag_q[i]   <= rs_tag_i;
                val1_q[i]  <= rs_val1_i;
                val2_q[i]  <= rs_val2_i;
                rdy1_q[i]  <= rs_rdy1_i;
                rdy2_q[i]  <= rs_rdy2_i;
                wait1_q[i] <= rs_wait1_i;
                wait2_q[i] <= rs_wait2_i;
            end else begin
                op_q[i]    <= op_q[src_idx[i]];
                tag_q[i]   <= tag_q[src_idx[i]];
                val1_q[i]  <= wake1[src_idx[i]] ? bc_data_i : val1_q[src_idx[i]];
                val2_q[i]  <= wake2[src_idx[i]] ? bc_data_i : val2_q[src_idx[i]];
                rdy1_q[i]  <= rdy1_q[src_idx[i]] || wake1[src_idx[i]];
                rdy2_q[i]  <= rdy2_q[src_idx[i]] || wake2[src_idx[i]];
                wait1_q[i] <= wait1_q[src_idx[i]];
                wait2_q[i] <= wait2_q[src_idx[i]];
            end
        end
    end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         issue_i,
    input  alu_op_e                      issue_op_i,
    input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag_i,
    input  logic [XLEN-1:0]              issue_a_i,
    input  logic [XLEN-1:0]              issue_b_i,
    output logic                         bc_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0] bc_tag_o,
    output logic [XLEN-1:0]              bc_data_o
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign shamt = issue_b_i[4:0];

    always_comb begin
        case (issue_op_i)
            ALU_ADD:  result = issue_a_i + issue_b_i;
            ALU_SUB:  result = issue_a_i - issue_b_i;
            ALU_SLL:  result = issue_a_i << shamt;
            ALU_SLT:  result = XLEN'($signed(issue_a_i) < $signed(issue_b_i));
            ALU_SLTU: result = XLEN'(issue_a_i < issue_b_i);
            ALU_XOR:  result = issue_a_i ^ issue_b_i;
            ALU_SRL:  result = issue_a_i >> shamt;
            ALU_SRA:  result = $signed(issue_a_i) >>> shamt;
            ALU_OR:   result = issue_a_i | issue_b_i;
            default:  result = issue_a_i & issue_b_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bc_valid_o <= 1'b0;
        end else begin
            bc_valid_o <= issue_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            bc_tag_o  <= issue_tag_i;
            bc_data_o <= result;
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           alloc_i,
    input  logic [REG_SEL-1:0]             alloc_rd_i,
    input  logic                           bc_valid_i,
    input  logic [$clog2(ROB_DEPTH)-1:0]   bc_tag_i,
    input  logic [XLEN-1:0]                bc_data_i,
    output logic [$clog2(ROB_DEPTH)-1:0]   tail_tag_o,
    output logic [ROB_DEPTH-1:0]           done_o,
    output logic [ROB_DEPTH-1:0][XLEN-1:0] data_o,
    output logic                           commit_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0]   commit_tag_o,
    output logic [REG_SEL-1:0]             commit_rd_o,
    output logic [XLEN-1:0]                commit_data_o,
    output logic                           credit_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W-1:0]               head_q;
    logic [TAG_W-1:0]               tail_q;
    logic [ROB_DEPTH-1:0]           vld_q;
    logic [ROB_DEPTH-1:0]           done_q;
    logic [REG_SEL-1:0]             rd_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0][XLEN-1:0] data_q;

    assign tail_tag_o     = tail_q;
    assign done_o         = done_q;
    assign data_o         = data_q;
    assign commit_valid_o = vld_q[head_q] && done_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_rd_o    = rd_q[head_q];
    assign commit_data_o  = data_q[head_q];
    // each commit frees one slot for the source
    assign credit_o       = commit_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q <= '0;
            tail_q <= '0;
            vld_q  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_i) begin
                vld_q[tail_q]  <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (bc_valid_i) begin
                done_q[bc_tag_i] <= 1'b1;
            end
            if (commit_valid_o) begin
                vld_q[head_q] <= 1'b0;
                head_q        <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (bc_valid_i) begin
            data_q[bc_tag_i] <= bc_data_i;
        end
    end

endmodule

//--- rtl/helios_core.sv
`timescale 1ns/10ps

module helios_core
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               insn_valid_i,
    input  logic [XLEN-1:0]    insn_i,
    output logic               insn_credit_o,
    output logic               commit_valid_o,
    output logic [REG_SEL-1:0] commit_rd_o,
    output logic [XLEN-1:0]    commit_data_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    alu_op_e                        dec_op;
    logic [REG_SEL-1:0]             dec_rs1;
    logic [REG_SEL-1:0]             dec_rs2;
    logic [REG_SEL-1:0]             dec_rd;
    logic                           dec_uses_rs2;
    logic [XLEN-1:0]                dec_imm;

    logic                           rs_write;
    alu_op_e                        rs_op;
    logic [TAG_W-1:0]               rs_tag;
    logic [XLEN-1:0]                rs_val1;
    logic [XLEN-1:0]                rs_val2;
    logic                           rs_rdy1;
    logic                           rs_rdy2;
    logic [TAG_W-1:0]               rs_wait1;
    logic [TAG_W-1:0]               rs_wait2;

    logic                           iss_valid;
    alu_op_e                        iss_op;
    logic [TAG_W-1:0]               iss_tag;
    logic [XLEN-1:0]                iss_a;
    logic [XLEN-1:0]                iss_b;

    logic                           bc_valid;
    logic [TAG_W-1:0]               bc_tag;
    logic [XLEN-1:0]                bc_data;

    logic [TAG_W-1:0]               tail_tag;
    logic [ROB_DEPTH-1:0]           rob_done;
    logic [ROB_DEPTH-1:0][XLEN-1:0] rob_data;
    logic [TAG_W-1:0]               commit_tag;

    insn_decoder u_decoder (
        .insn_i     (insn_i),
        .alu_op_o   (dec_op),
        .rs1_o      (dec_rs1),
        .rs2_o      (dec_rs2),
        .rd_o       (dec_rd),
        .uses_rs2_o (dec_uses_rs2),
        .imm_o      (dec_imm)
    );

    rename_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rename (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dispatch_i     (insn_valid_i),
        .alu_op_i       (dec_op),
        .rs1_i          (dec_rs1),
        .rs2_i          (dec_rs2),
        .rd_i           (dec_rd),
        .uses_rs2_i     (dec_uses_rs2),
        .imm_i          (dec_imm),
        .tail_tag_i     (tail_tag),
        .bc_valid_i     (bc_valid),
        .bc_tag_i       (bc_tag),
        .bc_data_i      (bc_data),
        .rob_done_i     (rob_done),
        .rob_data_i     (rob_data),
        .commit_valid_i (commit_valid_o),
        .commit_tag_i   (commit_tag),
        .commit_rd_i    (commit_rd_o),
        .commit_data_i  (commit_data_o),
        .rs_write_o     (rs_write),
        .rs_op_o        (rs_op),
        .rs_tag_o       (rs_tag),
        .rs_val1_o      (rs_val1),
        .rs_val2_o      (rs_val2),
        .rs_rdy1_o      (rs_rdy1),
        .rs_rdy2_o      (rs_rdy2),
        .rs_wait1_o     (rs_wait1),
        .rs_wait2_o     (rs_wait2)
    );

    alu_rs #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_alu_rs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rs_write_i  (rs_write),
        .rs_op_i     (rs_op),
        .rs_tag_i    (rs_tag),
        .rs_val1_i   (rs_val1),
        .rs_val2_i   (rs_val2),
        .rs_rdy1_i   (rs_rdy1),
        .rs_rdy2_i   (rs_rdy2),
        .rs_wait1_i  (rs_wait1),
        .rs_wait2_i  (rs_wait2),
        .bc_valid_i  (bc_valid),
        .bc_tag_i    (bc_tag),
        .bc_data_i   (bc_data),
        .issue_o     (iss_valid),
        .issue_op_o  (iss_op),
        .issue_tag_o (iss_tag),
        .issue_a_o   (iss_a),
        .issue_b_o   (iss_b)
    );

    alu_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_alu (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .issue_i     (iss_valid),
        .issue_op_i  (iss_op),
        .issue_tag_i (iss_tag),
        .issue_a_i   (iss_a),
        .issue_b_i   (iss_b),
        .bc_valid_o  (bc_valid),
        .bc_tag_o    (bc_tag),
        .bc_data_o   (bc_data)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .alloc_i        (insn_valid_i),
        .alloc_rd_i     (dec_rd),
        .bc_valid_i     (bc_valid),
        .bc_tag_i       (bc_tag),
        .bc_data_i      (bc_data),
        .tail_tag_o     (tail_tag),
        .done_o         (rob_done),
        .data_o         (rob_data),
        .commit_valid_o (commit_valid_o),
        .commit_tag_o   (commit_tag),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .credit_o       (insn_credit_o)
    );

endmodule

//--- dv/core_assert.sv
`timescale 1ns/10ps

module core_assert #(
    parameter int ROB_DEPTH = 8
) (
    input logic clk_i,
    input logic rst_i,
    input logic insn_valid_i,
    input logic insn_credit_i,
    input logic commit_valid_i
);

    int   credits;
    int   fail_cnt = 0;
    // first edge of reset still sees unreset outputs
    logic rst_seen = 1'b0;

    always_ff @(posedge clk_i) begin
        rst_seen <= rst_i;
        if (rst_i) begin
            credits <= ROB_DEPTH;
        end else begin
            credits <= credits + int'(insn_credit_i) - int'(insn_valid_i);
        end
    end

    a_valid_needs_credit: assert property (
        @(posedge clk_i) disable iff (rst_i) insn_valid_i |-> credits > 0
    ) else begin
        fail_cnt++;
        $error("insn_valid_i raised while the source held no credit");
    end

    a_credit_with_commit: assert property (
        @(posedge clk_i) disable iff (rst_i) insn_credit_i == commit_valid_i
    ) else begin
        fail_cnt++;
        $error("insn_credit_o differs from commit_valid_o");
    end

    a_quiet_in_reset: assert property (
        @(posedge clk_i) (rst_i && rst_seen) |-> (!insn_credit_i && !commit_valid_i)
    ) else begin
        fail_cnt++;
        $error("commit or credit raised during reset");
    end

endmodule

//--- dv/commit_checker.sv
`timescale 1ns/10ps

module commit_checker
    import helios_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               insn_valid_i,
    input  logic [XLEN-1:0]    insn_i,
    input  logic               insn_credit_i,
    input  logic               commit_valid_i,
    input  logic [REG_SEL-1:0] commit_rd_i,
    input  logic [XLEN-1:0]    commit_data_i,
    output int                 commit_cnt_o,
    output int                 err_cnt_o
);

    logic [XLEN-1:0]    pending [$];
    logic [XLEN-1:0]    model_arf [32];
    logic [XLEN-1:0]    cur_insn;
    logic [XLEN-1:0]    exp_data;
    logic [REG_SEL-1:0] exp_rd;
    int                 commits = 0;
    int                 errs = 0;

    assign commit_cnt_o = commits;
    assign err_cnt_o    = errs;

    // sequential execution of one instruction on the model registers
    function automatic logic [XLEN-1:0] execute(input logic [XLEN-1:0] insn);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            reg_form;
        reg_form = (insn[6:0] == OPC_OP);
        a = model_arf[insn[19:15]];
        b = reg_form ? model_arf[insn[24:20]] : {{20{insn[31]}}, insn[31:20]};
        case (insn[14:12])
            3'b000: res = (reg_form && insn[30]) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (insn[30]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            pending.delete();
            for (int r = 0; r < 32; r++) begin
                model_arf[r] = '0;
            end
        end else begin
            if (commit_valid_i) begin
                if (pending.size() == 0) begin
                    $display("%0t: commit seen with no instruction outstanding", $time);
                    errs++;
                end else begin
                    cur_insn = pending.pop_front();
                    exp_rd   = cur_insn[11:7];
                    exp_data = execute(cur_insn);
                    if (commit_rd_i !== exp_rd) begin
                        $display("[FAIL] %0t commit_rd_o: got %0d expected %0d",
                                 $time, commit_rd_i, exp_rd);
                        errs++;
                    end
                    if (commit_data_i !== exp_data) begin
                        $display("[FAIL] %0t commit_data_o: got %h expected %h",
                                 $time, commit_data_i, exp_data);
                        errs++;
                    end
                    // x0 stays zero
                    if (exp_rd != '0) begin
                        model_arf[exp_rd] = exp_data;
                    end
                    commits++;
                end
            end
            if (insn_credit_i !== commit_valid_i) begin
                $display("%0t: credit pulse does not match a commit", $time);
                errs++;
            end
            if (insn_valid_i) begin
                pending.push_back(insn_i);
            end
        end
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/10ps

module tb_top
    import helios_pkg::*;
#(
    parameter int ROB_DEPTH = 8
);

    localparam int WAIT_LIMIT = 1000;

    logic               clk_i;
    logic               rst_i;
    logic               insn_valid_i;
    logic [XLEN-1:0]    insn_i;
    logic               insn_credit_o;
    logic               commit_valid_o;
    logic [REG_SEL-1:0] commit_rd_o;
    logic [XLEN-1:0]    commit_data_o;

    int credits;
    int n_tests = 0;
    int tb_errs = 0;
    int chk_commits;
    int chk_errs;

    helios_core #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .insn_valid_i   (insn_valid_i),
        .insn_i         (insn_i),
        .insn_credit_o  (insn_credit_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    commit_checker u_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .insn_valid_i   (insn_valid_i),
        .insn_i         (insn_i),
        .insn_credit_i  (insn_credit_o),
        .commit_valid_i (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_data_i  (commit_data_o),
        .commit_cnt_o   (chk_commits),
        .err_cnt_o      (chk_errs)
    );

    bind helios_core core_assert #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_assert (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .insn_valid_i   (insn_valid_i),
        .insn_credit_i  (insn_credit_o),
        .commit_valid_i (commit_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // source side credit count
    always @(posedge clk_i) begin
        if (rst_i) begin
            credits <= ROB_DEPTH;
        end else begin
            credits <= credits + int'(insn_credit_o) - int'(insn_valid_i);
        end
    end

    function automatic logic [XLEN-1:0] op_insn(input logic [2:0] f3, input logic alt,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] imm_insn(input logic [2:0] f3, input logic alt,
                                                 input logic [11:0] imm, input logic [4:0] rd,
                                                 input logic [4:0] rs1);
        logic [11:0] field;
        field = imm;
        // shifts keep only shamt plus the arithmetic bit
        if (f3 == 3'b001) begin
            field = {7'b0000000, imm[4:0]};
        end else if (f3 == 3'b101) begin
            field = {1'b0, alt, 5'b00000, imm[4:0]};
        end
        return {field, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [XLEN-1:0] random_insn(input int lo, input int hi);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic       alt;
        rd  = 5'($urandom_range(hi, lo));
        rs1 = 5'($urandom_range(hi, lo));
        rs2 = 5'($urandom_range(hi, lo));
        f3  = 3'($urandom);
        alt = 1'($urandom);
        if ($urandom_range(1, 0) == 1) begin
            return op_insn(f3, alt, rd, rs1, rs2);
        end
        return imm_insn(f3, alt, 12'($urandom), rd, rs1);
    endfunction

    function automatic int total_errors();
        return chk_errs + tb_errs + dut_i.u_assert.fail_cnt;
    endfunction

    task automatic finish_run();
        $display("tests %0d, commits %0d, errors %0d", n_tests, chk_commits,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("%0t: timeout, %s", $time, what);
        tb_errs++;
        finish_run();
    endtask

    // called and returns on a falling edge
    task automatic send(input logic [XLEN-1:0] insn);
        int t;
        t = 0;
        while (credits == 0) begin
            @(negedge clk_i);
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("no credit came back to the source");
            end
        end
        insn_valid_i = 1'b1;
        insn_i       = insn;
        @(negedge clk_i);
        insn_valid_i = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (credits != ROB_DEPTH) begin
            @(negedge clk_i);
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("outstanding instructions never committed");
            end
        end
    endtask

    task automatic report_test(input string name);
        n_tests++;
        $display("test %0d %s finished, errors so far %0d", n_tests, name,
                 total_errors());
    endtask

    initial begin
        rst_i        = 1'b1;
        insn_valid_i = 1'b0;
        insn_i       = '0;
        void'($urandom(32'h6034_e2ab));
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;

        // idle core while the checker watches for stray commits or credits
        repeat (20) @(negedge clk_i);
        report_test("reset and idle");

        for (int i = 1; i <= 4; i++) begin
            send(imm_insn(3'b000, 1'b0, 12'($urandom), 5'(i), 5'd0));
        end
        for (int i = 0; i < 60; i++) begin
            send(op_insn(3'($urandom), 1'($urandom), 5'($urandom_range(4, 1)),
                         5'($urandom_range(4, 1)), 5'($urandom_range(4, 1))));
        end
        drain();
        report_test("dependent op chain");

        for (int i = 0; i < 48; i++) begin
            send(imm_insn(3'(i % 8), 1'((i / 8) % 2), 12'($urandom),
                          5'($urandom_range(7, 1)), 5'($urandom_range(7, 1))));
        end
        drain();
        report_test("op-imm immediates and shifts");

        // chained burst shows its order in rd and data
        for (int i = 0; i < ROB_DEPTH; i++) begin
            send(imm_insn(3'b000, 1'b0, 12'(i * 5 - 9), 5'(i + 1), 5'(i)));
        end
        drain();
        report_test("credit burst");

        send(imm_insn(3'b000, 1'b0, 12'd5, 5'd0, 5'd1));
        send(op_insn(3'b000, 1'b0, 5'd0, 5'd2, 5'd3));
        send(op_insn(3'b000, 1'b0, 5'd5, 5'd0, 5'd1));
        send(imm_insn(3'b000, 1'b0, 12'hfff, 5'd6, 5'd0));
        send(op_insn(3'b110, 1'b0, 5'd7, 5'd0, 5'd0));
        send(op_insn(3'b000, 1'b1, 5'd8, 5'd0, 5'd6));
        drain();
        report_test("x0 reads and writes");

        for (int i = 0; i < 2000; i++) begin
            send(random_insn(0, 31));
        end
        drain();
        report_test("random mix");

        finish_run();
    end

endmodule

//--- sources.f
rtl/helios_pkg.sv
rtl/insn_decoder.sv
rtl/rename_unit.sv
rtl/alu_rs.sv
rtl/alu_unit.sv
rtl/reorder_buffer.sv
rtl/helios_core.sv
dv/core_assert.sv
dv/commit_checker.sv
dv/tb_top.sv
